/* filelist.f */
source/MemoryTypes.sv
source/MemoryRequestIf.sv
source/QueuePointer.sv
source/MemoryRequestQueue.sv
source/MemoryArray.sv
source/MemoryModelTop.sv
tb/MemoryModelTb.sv

/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = MemoryModelTb
FILELIST  = filelist.f
BUILD_DIR = obj_dir

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# Rebuild only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* tb/MemoryModelTb.sv */
// ==============================
// Memory model testbench, random traffic checked against
// a reference memory and a tag scoreboard
// ==============================

`timescale 1ns/1ps
`default_nettype none

module MemoryModelTb;

    localparam int RESET_CYCLES = 10;
    localparam int NUM_REQUESTS = 300;
    localparam logic [31:0] LFSR_SEED = 32'd76766;
    localparam MemoryTypes::MemAddrPath ADDR_BASE = 8'h50;

    // Response window after the push cycle
    localparam int MIN_LATENCY = 2;
    localparam int MAX_LATENCY = 1 + MemoryTypes::MEM_REQ_QUEUE_SIZE * MemoryTypes::LATENCY_RANGE;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_REQUESTS * (MAX_LATENCY + 1);

    // One outstanding request as the scoreboard sees it
    typedef struct packed {
        MemoryTypes::MemoryRequestData req;
        MemoryTypes::MemDataPath rdata;
        int cycle;
        bit fromEmpty;
    } ExpectedResponse;

    logic clk = 1'b0;
    logic rst;
    logic reqValid;
    logic reqIsWrite;
    MemoryTypes::MemAddrPath reqAddr;
    MemoryTypes::MemDataPath reqWdata;
    MemoryTypes::MemTagPath reqTag;
    logic respValid;
    logic respIsWrite;
    MemoryTypes::MemTagPath respTag;
    MemoryTypes::MemDataPath respRdata;

    int cycleCount = 0;
    int pushCount = 0;
    int minEmptyLatency = 1000000;
    int maxEmptyLatency = -1;
    logic [31:0] lfsrState;
    MemoryTypes::MemTagPath nextTag;
    MemoryTypes::MemDataPath refMem [MemoryTypes::MEM_WORDS];
    ExpectedResponse scoreboard [$];

    MemoryModelTop UUT (
        .clk(clk),
        .rst(rst),
        .reqValid(reqValid),
        .reqIsWrite(reqIsWrite),
        .reqAddr(reqAddr),
        .reqWdata(reqWdata),
        .reqTag(reqTag),
        .respValid(respValid),
        .respIsWrite(respIsWrite),
        .respTag(respTag),
        .respRdata(respRdata)
    );

    always #20 clk = ~clk;

    task automatic failRun(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    function automatic string mismatchLine(
        input string check,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        return $sformatf("FAILED %s: expected 0x%08h, actual 0x%08h", check, expected, actual);
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic drawBits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    // Random request, applied to the reference memory right away
    task automatic pushRequest();
        logic [31:0] bits;
        ExpectedResponse entry;
        drawBits(1, bits);
        entry.req.isWrite = bits[0];
        drawBits(4, bits);
        entry.req.addr = ADDR_BASE | MemoryTypes::MemAddrPath'(bits[3:0]);
        drawBits(MemoryTypes::MEM_DATA_WIDTH, bits);
        entry.req.wdata = bits;
        entry.req.tag = nextTag;
        entry.cycle = cycleCount;
        entry.fromEmpty = (scoreboard.size() == 0);
        if (entry.req.isWrite) begin
            refMem[entry.req.addr] = entry.req.wdata;
            entry.rdata = '0;
        end else begin
            entry.rdata = refMem[entry.req.addr];
        end
        scoreboard.push_back(entry);
        reqValid = 1'b1;
        reqIsWrite = entry.req.isWrite;
        reqAddr = entry.req.addr;
        reqWdata = entry.req.wdata;
        reqTag = entry.req.tag;
        nextTag = nextTag + MemoryTypes::MemTagPath'(1);
        pushCount++;
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > TIMEOUT_CYCLES) begin
            failRun($sformatf("Timeout after %0d cycles with %0d responses still outstanding",
                cycleCount, scoreboard.size()));
        end
    end

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin : checkResponse
        ExpectedResponse head;
        int latency;
        if (cycleCount > 0 && pushCount == 0) begin
            assert (respValid == 1'b0)
                else failRun("respValid was raised before any request was pushed");
        end
        if (respValid) begin
            assert (scoreboard.size() > 0)
                else failRun("Response arrived with no request outstanding");
            head = scoreboard.pop_front();
            latency = cycleCount - head.cycle;
            assert (respTag == head.req.tag)
                else failRun(mismatchLine("tagOrder", 32'(head.req.tag), 32'(respTag)));
            assert (respIsWrite == head.req.isWrite)
                else failRun(mismatchLine("isWriteOrder", 32'(head.req.isWrite),
                    32'(respIsWrite)));
            if (head.req.isWrite) begin
                // Write responses carry zero data
                assert (respRdata == head.rdata)
                    else failRun(mismatchLine("writeData", head.rdata, respRdata));
            end else begin
                assert (respRdata == head.rdata)
                    else failRun(mismatchLine("readData", head.rdata, respRdata));
            end
            assert (latency >= MIN_LATENCY && latency <= MAX_LATENCY)
                else failRun($sformatf("FAILED latencyBounds: expected %0d to %0d, actual %0d",
                    MIN_LATENCY, MAX_LATENCY, latency));
            // Only an idle queue shows the bare head wait
            if (head.fromEmpty) begin
                if (latency < minEmptyLatency) begin
                    minEmptyLatency = latency;
                end
                if (latency > maxEmptyLatency) begin
                    maxEmptyLatency = latency;
                end
            end
        end
    end

    initial begin
        logic [31:0] bits;
        logic heavy;
        logic wantPush;
        rst = 1'b1;
        reqValid = 1'b0;
        reqIsWrite = 1'b0;
        reqAddr = '0;
        reqWdata = '0;
        reqTag = '0;
        nextTag = '0;
        lfsrState = LFSR_SEED;
        for (int i = 0; i < MemoryTypes::MEM_WORDS; i++) begin
            refMem[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        // Light and heavy traffic alternate every 50 requests
        while (pushCount < NUM_REQUESTS) begin
            @(posedge clk);
            #1;
            reqValid = 1'b0;
            heavy = ((pushCount / 50) % 2) == 1;
            if (heavy) begin
                drawBits(2, bits);
                wantPush = (bits[1:0] != 2'b00);
            end else begin
                drawBits(3, bits);
                wantPush = (bits[2:0] == 3'b000);
            end
            if (wantPush && scoreboard.size() < MemoryTypes::MEM_REQ_QUEUE_SIZE) begin
                pushRequest();
            end
        end
        @(posedge clk);
        #1;
        reqValid = 1'b0;

        // Drain, the timeout catches a stuck model
        while (scoreboard.size() != 0) begin
            @(posedge clk);
        end

        if (maxEmptyLatency > minEmptyLatency) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            failRun($sformatf("Latency never varied for requests into an idle queue (%0d to %0d)",
                minEmptyLatency, maxEmptyLatency));
        end
    end

endmodule : MemoryModelTb

`default_nettype wire

/* source/MemoryModelTop.sv */
// ==============================
// Variable latency main memory model, top level
// ==============================

`timescale 1ns/1ps
`default_nettype none

module MemoryModelTop (
    input  logic clk,
    input  logic rst,

    // Request side, one strobe per request
    input  logic reqValid,
    input  logic reqIsWrite,
    input  MemoryTypes::MemAddrPath reqAddr,
    input  MemoryTypes::MemDataPath reqWdata,
    input  MemoryTypes::MemTagPath reqTag,

    // Responses come back in request order
    output logic respValid,
    output logic respIsWrite,
    output MemoryTypes::MemTagPath respTag,
    output MemoryTypes::MemDataPath respRdata
);

    MemoryTypes::MemoryRequestData reqData;

    MemoryRequestIf issueIf ();

    assign reqData.isWrite = reqIsWrite;
    assign reqData.addr = reqAddr;
    assign reqData.wdata = reqWdata;
    assign reqData.tag = reqTag;

    MemoryRequestQueue requestQueue (
        .clk(clk),
        .rst(rst),
        .reqValid(reqValid),
        .reqData(reqData),
        .issue(issueIf.sender)
    );

    MemoryArray memoryArray (
        .clk(clk),
        .rst(rst),
        .issue(issueIf.receiver),
        .respValid(respValid),
        .respIsWrite(respIsWrite),
        .respTag(respTag),
        .respRdata(respRdata)
    );

endmodule : MemoryModelTop

`default_nettype wire

/* source/MemoryArray.sv */
// ==============================
// Word storage that performs issued requests and
// registers their responses
// ==============================

`timescale 1ns/1ps
`default_nettype none

module MemoryArray (
    input  logic clk,
    input  logic rst,
    MemoryRequestIf.receiver issue,
    output logic respValid,
    output logic respIsWrite,
    output MemoryTypes::MemTagPath respTag,
    output MemoryTypes::MemDataPath respRdata
);

    MemoryTypes::MemDataPath storage [MemoryTypes::MEM_WORDS];

    // Contents start at zero and survive reset
    initial begin
        for (int i = 0; i < MemoryTypes::MEM_WORDS; i++) begin
            storage[i] = '0;
        end
    end

    // Response strobe is the only control state here
    always_ff @(posedge clk) begin
        if (rst) begin
            respValid <= 1'b0;
        end else begin
            respValid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            respIsWrite <= issue.isWrite;
            respTag <= issue.tag;
            if (issue.isWrite) begin
                storage[issue.addr] <= issue.wdata;
                // Writes return zero data
                respRdata <= '0;
            end else begin
                respRdata <= storage[issue.addr];
            end
        end
    end

    // Queue must never hand over a request with unknown fields
    issueKnown: assert property (
        @(posedge clk) disable iff (rst)
        issue.valid |-> !$isunknown({issue.isWrite, issue.addr, issue.wdata, issue.tag})
    ) else $error("MemoryArray: unknown request fields on issue");

endmodule : MemoryArray

`default_nettype wire

/* source/MemoryRequestQueue.sv */
// ==============================
// Request FIFO that releases its head after a random
// number of cycles
// ==============================

`timescale 1ns/1ps
`default_nettype none

module MemoryRequestQueue (
    input  logic clk,
    input  logic rst,
    input  logic reqValid,
    input  MemoryTypes::MemoryRequestData reqData,
    MemoryRequestIf.sender issue
);

    logic pop;
    logic full;
    logic empty;
    logic [$clog2(MemoryTypes::MEM_REQ_QUEUE_SIZE)-1:0] headPtr;
    logic [$clog2(MemoryTypes::MEM_REQ_QUEUE_SIZE)-1:0] tailPtr;

    MemoryTypes::MemoryRequestData entries [MemoryTypes::MEM_REQ_QUEUE_SIZE];
    MemoryTypes::MemoryRequestData headReq;

    MemoryTypes::LatencyCountPath countReg;
    MemoryTypes::LatencyCountPath countNext;
    MemoryTypes::LatencyCountPath targetWait;
    MemoryTypes::MemoryRandPath randReg;
    MemoryTypes::MemoryRandPath randNext;

    // 32-bit xorshift, shifts 13, 17, 5
    function automatic MemoryTypes::MemoryRandPath xorshift(
        input MemoryTypes::MemoryRandPath x
    );
        MemoryTypes::MemoryRandPath y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    QueuePointer #(
        .SIZE(MemoryTypes::MEM_REQ_QUEUE_SIZE)
    ) pointer (
        .clk(clk),
        .rst(rst),
        .push(reqValid),
        .pop(pop),
        .full(full),
        .empty(empty),
        .headPtr(headPtr),
        .tailPtr(tailPtr)
    );

    // Payload storage, no reset needed
    always_ff @(posedge clk) begin
        if (reqValid) begin
            entries[tailPtr] <= reqData;
        end
    end

    // Wait chosen for the current head
    assign targetWait = MemoryTypes::LatencyCountPath'(
        randReg % MemoryTypes::LATENCY_RANGE);

    always_comb begin
        pop = 1'b0;
        countNext = '0;
        randNext = randReg;
        if (!empty) begin
            if (countReg == targetWait) begin
                // Head has waited long enough, issue it now
                pop = 1'b1;
                randNext = xorshift(randReg);
            end else begin
                countNext = countReg + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            countReg <= '0;
            randReg <= MemoryTypes::LATENCY_RAND_SEED;
        end else begin
            countReg <= countNext;
            randReg <= randNext;
        end
    end

    // Head fields go out combinationally in the pop cycle
    assign headReq = entries[headPtr];
    assign issue.valid = pop;
    assign issue.isWrite = headReq.isWrite;
    assign issue.addr = headReq.addr;
    assign issue.wdata = headReq.wdata;
    assign issue.tag = headReq.tag;

    // Requester must keep outstanding requests within the queue depth
    pushNotFull: assert property (@(posedge clk) disable iff (rst) reqValid |-> !full)
        else $error("MemoryRequestQueue: too many outstanding requests");

endmodule : MemoryRequestQueue

`default_nettype wire

/* source/QueuePointer.sv */
// ==============================
// Circular buffer head/tail pointers with occupancy,
// full and empty flags
// ==============================

`timescale 1ns/1ps
`default_nettype none

module QueuePointer #(
    parameter int SIZE = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic pop,
    output logic full,
    output logic empty,
    output logic [$clog2(SIZE)-1:0] headPtr,
    output logic [$clog2(SIZE)-1:0] tailPtr
);

    // One extra bit so the count can reach SIZE
    logic [$clog2(SIZE):0] count;

    // Advance by one and wrap at SIZE, which need not be a power of two
    function automatic logic [$clog2(SIZE)-1:0] nextPtr(
        input logic [$clog2(SIZE)-1:0] ptr
    );
        if (int'(ptr) == SIZE - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tailPtr <= nextPtr(tailPtr);
            end
            if (pop) begin
                headPtr <= nextPtr(headPtr);
            end
            // Simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign full = (int'(count) == SIZE);
    assign empty = (count == '0);

    // The owner must only pop what it has pushed
    popNotEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("QueuePointer: pop while empty");

endmodule : QueuePointer

`default_nettype wire

/* source/MemoryRequestIf.sv */
// ==============================
// Issue strobe from request queue to memory array
// ==============================

`timescale 1ns/1ps
`default_nettype none

interface MemoryRequestIf;

    // valid is high for one cycle per request; fields only count then
    logic valid;
    logic isWrite;
    MemoryTypes::MemAddrPath addr;
    MemoryTypes::MemDataPath wdata;
    MemoryTypes::MemTagPath tag;

    modport sender (output valid, isWrite, addr, wdata, tag);

    // No ready signal, the receiver takes every issue
    modport receiver (input valid, isWrite, addr, wdata, tag);

endinterface : MemoryRequestIf

`default_nettype wire

/* source/MemoryTypes.sv */
// ==============================
// Memory model shared widths, queue depth, latency range
// and request types
// ==============================

`default_nettype none

package MemoryTypes;

    // Storage geometry, word addressed
    localparam int MEM_ADDR_WIDTH = 8;
    localparam int MEM_DATA_WIDTH = 32;
    localparam int MEM_TAG_WIDTH = 4;
    localparam int MEM_WORDS = 1 << MEM_ADDR_WIDTH;

    // Most requests that may be outstanding at once
    localparam int MEM_REQ_QUEUE_SIZE = 8;

    // Extra wait at the queue head is 0 to LATENCY_RANGE-1 cycles
    localparam int LATENCY_RANGE = 8;

    typedef logic [MEM_ADDR_WIDTH-1:0] MemAddrPath;
    typedef logic [MEM_DATA_WIDTH-1:0] MemDataPath;
    typedef logic [MEM_TAG_WIDTH-1:0] MemTagPath;
    typedef logic [$clog2(LATENCY_RANGE)-1:0] LatencyCountPath;
    typedef logic [31:0] MemoryRandPath;

    // Xorshift state after reset, must be nonzero
    localparam MemoryRandPath LATENCY_RAND_SEED = 32'h2F6B_93A5;

    // One request as held in the queue
    typedef struct packed {
        logic isWrite;
        MemAddrPath addr;
        MemDataPath wdata;
        MemTagPath tag;
    } MemoryRequestData;

endpackage : MemoryTypes

`default_nettype wire
